// ==== hpu_vectors.txt ====
// Column 1: instruction word in hex, opcode in the top nibble
// Column 2: expected acknowledge word in hex
00000000 00000000
10000001 10000001
2abc1234 2abc1234
3fff0000 3fff0000
10a5a5a5 10a5a5a5
21234567 21234567
3000beef 3000beef
0deadbee 0deadbee
5a5a5a5a fa5a5a5a
1c0ffee0 1c0ffee0
2fedcba9 2fedcba9
e0000001 f0000001
30f0f0f0 30f0f0f0
f1234567 f1234567
07654321 07654321
8badf00d fbadf00d

// ==== hpu_slr_shell.f ====
+incdir+.
hpu_pkg.sv
prc_reset_chain.sv
isc_in_buffer.sv
isc_dispatch.sv
part_pipe.sv
isc_executor.sv
isc_ack_buffer.sv
hpu_slr_shell.sv
tb_hpu_slr_shell.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the testbench with Verilator, result taken from the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -Wno-fatal \
  --top-module tb_hpu_slr_shell \
  -f hpu_slr_shell.f \
  -o sim_hpu
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/sim_hpu > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "^TB PASSED$" "$LOG"; then
  echo "Result: pass"
  exit 0
fi
echo "Result: fail"
exit 1

// ==== tb_hpu_slr_shell.sv ====
`timescale 1ns/1ps
`include "hpu_settings.svh"

module tb_hpu_slr_shell;

  localparam int NUM_VEC     = 16;
  localparam int W           = `HPU_INST_W;
  localparam int STALL_CYC   = 30;
  localparam int TIMEOUT_CYC = NUM_VEC * 40 + 200;

  logic         prc_clk = 1'b0;
  logic         cfg_srst_n;
  logic [W-1:0] isc_dop;
  logic         isc_dop_vld;
  logic         isc_dop_rdy;
  logic [W-1:0] isc_ack;
  logic         isc_ack_vld;
  logic         isc_ack_rdy;
  logic         irq_clr;
  logic         interrupt;
  logic         prc_ce;

  // Even entries hold instructions, odd entries their expected acks
  logic [W-1:0] vec_mem [2*NUM_VEC];
  int           mismatch_cnt = 0;
  int           other_cnt    = 0;
  int           cycle_cnt    = 0;
  int           recv_cnt     = 0;
  logic         saw_illegal  = 1'b0;
  logic [15:0]  lfsr         = 16'd82;

  hpu_slr_shell i_hpu_slr_shell (
    .prc_clk     (prc_clk),
    .cfg_srst_n  (cfg_srst_n),
    .isc_dop     (isc_dop),
    .isc_dop_vld (isc_dop_vld),
    .isc_dop_rdy (isc_dop_rdy),
    .isc_ack     (isc_ack),
    .isc_ack_vld (isc_ack_vld),
    .isc_ack_rdy (isc_ack_rdy),
    .irq_clr     (irq_clr),
    .interrupt   (interrupt),
    .prc_ce      (prc_ce)
  );

  always #50 prc_clk = ~prc_clk;

  // ========================================
  // Helpers
  // ========================================
  task automatic compare_value(input string name, input logic [W-1:0] got,
                               input logic [W-1:0] exp);
    if (got !== exp) begin
      mismatch_cnt++;
      $display("Mismatch at %0d ns: %s is %h, expected %h", $time, name, got, exp);
    end
  endtask

  // Galois LFSR, taps 16 14 13 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  // Run limit
  always @(posedge prc_clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt == TIMEOUT_CYC) begin
      $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYC);
      $display("TB FAILED");
      $finish;
    end
  end

  // ========================================
  // Stimulus and response
  // ========================================
  task automatic apply_reset();
    cfg_srst_n <= 1'b0;
    repeat (2) @(posedge prc_clk);
    cfg_srst_n <= 1'b1;
    // Parts stay in reset for three cycles after the release
    repeat (3) begin
      @(posedge prc_clk);
      compare_value("isc_dop_rdy", W'(isc_dop_rdy), '0);
      compare_value("isc_ack_vld", W'(isc_ack_vld), '0);
      compare_value("interrupt", W'(interrupt), '0);
      compare_value("prc_ce", W'(prc_ce), '0);
    end
    @(posedge prc_clk);
    compare_value("prc_ce", W'(prc_ce), W'(1'b1));
    while (!prc_ce) begin
      @(posedge prc_clk);
    end
  endtask

  task automatic send_vectors();
    for (int i = 0; i < NUM_VEC; i++) begin
      isc_dop     <= vec_mem[2*i];
      isc_dop_vld <= 1'b1;
      @(posedge prc_clk);
      while (!isc_dop_rdy) begin
        @(posedge prc_clk);
      end
    end
    isc_dop_vld <= 1'b0;
  endtask

  task automatic receive_acks();
    logic [W-1:0] exp;
    while (recv_cnt < NUM_VEC) begin
      @(posedge prc_clk);
      if (isc_ack_vld && isc_ack_rdy) begin
        exp = vec_mem[2*recv_cnt+1];
        compare_value("isc_ack", isc_ack, exp);
        // Error opcode marks an illegal word
        if (exp[W-1 -: `HPU_OP_W] == {`HPU_OP_W{1'b1}}) begin
          saw_illegal = 1'b1;
        end
        if (saw_illegal) begin
          compare_value("interrupt", W'(interrupt), W'(1'b1));
        end
        recv_cnt++;
      end
    end
  endtask

  task automatic drive_ack_ready();
    int accepted;
    accepted = 0;
    isc_ack_rdy <= 1'b0;
    for (int c = 0; c < STALL_CYC; c++) begin
      @(posedge prc_clk);
      if (isc_dop_vld && isc_dop_rdy) begin
        accepted++;
      end
    end
    // FIFO credits plus the one-entry input buffer
    compare_value("accepted under stall", W'(accepted), W'(`HPU_ACK_DEPTH + 1));
    compare_value("isc_dop_rdy", W'(isc_dop_rdy), '0);
    while (recv_cnt < NUM_VEC) begin
      isc_ack_rdy <= lfsr[0];
      lfsr = lfsr_next(lfsr);
      @(posedge prc_clk);
    end
    isc_ack_rdy <= 1'b1;
  endtask

  task automatic check_tail();
    // Nothing may follow the last expected ack
    repeat (20) begin
      @(posedge prc_clk);
      compare_value("isc_ack_vld", W'(isc_ack_vld), '0);
    end
    compare_value("interrupt", W'(interrupt), W'(saw_illegal));
    irq_clr <= 1'b1;
    @(posedge prc_clk);
    irq_clr <= 1'b0;
    @(posedge prc_clk);
    compare_value("interrupt", W'(interrupt), '0);
  endtask

  initial begin : main_seq
    int fd;
    cfg_srst_n  <= 1'b0;
    isc_dop     <= '0;
    isc_dop_vld <= 1'b0;
    isc_ack_rdy <= 1'b0;
    irq_clr     <= 1'b0;
    fd = $fopen("hpu_vectors.txt", "r");
    if (fd == 0) begin
      other_cnt++;
      $display("Could not open the vector file hpu_vectors.txt");
    end else begin
      $fclose(fd);
      $readmemh("hpu_vectors.txt", vec_mem);
      apply_reset();
      fork
        send_vectors();
        receive_acks();
        drive_ack_ready();
      join
      check_tail();
    end
    $display("Errors: %0d mismatches, %0d other failures", mismatch_cnt, other_cnt);
    if (mismatch_cnt == 0 && other_cnt == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

// ==== hpu_slr_shell.sv ====
`timescale 1ns/1ps
`include "hpu_settings.svh"

module hpu_slr_shell (
  input  logic              prc_clk,
  input  logic              cfg_srst_n,
  input  hpu_pkg::pe_inst_t isc_dop,
  input  logic              isc_dop_vld,
  output logic              isc_dop_rdy,
  output hpu_pkg::pe_inst_t isc_ack,
  output logic              isc_ack_vld,
  input  logic              isc_ack_rdy,
  input  logic              irq_clr,
  output logic              interrupt,
  output logic              prc_ce
);

  import hpu_pkg::*;

  logic [2:0] part_srst_n;
  pe_inst_t   buf_inst;
  logic       buf_vld;
  logic       buf_rdy;
  pe_inst_t   fwd_inst;
  logic       fwd_avail;
  pe_inst_t   exe_inst;
  logic       exe_avail;
  pe_inst_t   exe_ack;
  logic       exe_ack_avail;
  pe_inst_t   ret_ack;
  logic       ret_ack_avail;
  logic       ack_pop;

  // ========================================
  // Input side
  // ========================================
  prc_reset_chain i_prc_reset_chain (
    .prc_clk     (prc_clk),
    .cfg_srst_n  (cfg_srst_n),
    .part_srst_n (part_srst_n),
    .prc_ce      (prc_ce)
  );

  isc_in_buffer i_isc_in_buffer (
    .prc_clk     (prc_clk),
    .srst_n      (part_srst_n[0]),
    .isc_dop     (isc_dop),
    .isc_dop_vld (isc_dop_vld),
    .isc_dop_rdy (isc_dop_rdy),
    .buf_inst    (buf_inst),
    .buf_vld     (buf_vld),
    .buf_rdy     (buf_rdy)
  );

  // ========================================
  // Processing part
  // ========================================
  isc_dispatch i_isc_dispatch (
    .prc_clk   (prc_clk),
    .srst_n    (part_srst_n[0]),
    .buf_inst  (buf_inst),
    .buf_vld   (buf_vld),
    .buf_rdy   (buf_rdy),
    .ack_pop   (ack_pop),
    .fwd_inst  (fwd_inst),
    .fwd_avail (fwd_avail)
  );

  // Pipe flops sit in part 2, launch stage cleared by the sender
  part_pipe #(
    .DEPTH (`HPU_PART_PIPE)
  ) fwd_pipe (
    .prc_clk    (prc_clk),
    .in_srst_n  (part_srst_n[0]),
    .out_srst_n (part_srst_n[1]),
    .in_data    (fwd_inst),
    .in_avail   (fwd_avail),
    .out_data   (exe_inst),
    .out_avail  (exe_avail)
  );

  isc_executor i_isc_executor (
    .prc_clk     (prc_clk),
    .srst_n      (part_srst_n[2]),
    .in_inst     (exe_inst),
    .in_avail    (exe_avail),
    .irq_clr     (irq_clr),
    .ack         (exe_ack),
    .ack_avail   (exe_ack_avail),
    .irq_illegal (interrupt)
  );

  part_pipe #(
    .DEPTH (`HPU_RET_PIPE)
  ) ret_pipe (
    .prc_clk    (prc_clk),
    .in_srst_n  (part_srst_n[2]),
    .out_srst_n (part_srst_n[1]),
    .in_data    (exe_ack),
    .in_avail   (exe_ack_avail),
    .out_data   (ret_ack),
    .out_avail  (ret_ack_avail)
  );

  // ========================================
  // Output side
  // ========================================
  isc_ack_buffer i_isc_ack_buffer (
    .prc_clk     (prc_clk),
    .srst_n      (part_srst_n[0]),
    .wr_ack      (ret_ack),
    .wr_avail    (ret_ack_avail),
    .isc_ack     (isc_ack),
    .isc_ack_vld (isc_ack_vld),
    .isc_ack_rdy (isc_ack_rdy),
    .ack_pop     (ack_pop)
  );

endmodule

// ==== isc_ack_buffer.sv ====
`timescale 1ns/1ps
`include "hpu_settings.svh"

module isc_ack_buffer (
  input  logic              prc_clk,
  input  logic              srst_n,
  input  hpu_pkg::pe_inst_t wr_ack,
  input  logic              wr_avail,
  output hpu_pkg::pe_inst_t isc_ack,
  output logic              isc_ack_vld,
  input  logic              isc_ack_rdy,
  output logic              ack_pop
);

  import hpu_pkg::*;

  // Depth is a power of two, pointers carry one wrap bit
  localparam int DEPTH = `HPU_ACK_DEPTH;
  localparam int AW    = $clog2(DEPTH);

  pe_inst_t    mem [DEPTH];
  logic [AW:0] wr_ptr;
  logic [AW:0] rd_ptr;

  // No full check, dispatch credits never overrun the FIFO
  always_ff @(posedge prc_clk) begin
    if (wr_avail) begin
      mem[wr_ptr[AW-1:0]] <= wr_ack;
    end
  end

  always_ff @(posedge prc_clk) begin
    if (!srst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (wr_avail) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (ack_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  // Head stays put until it is taken
  assign isc_ack_vld = (wr_ptr != rd_ptr);
  assign isc_ack     = mem[rd_ptr[AW-1:0]];
  // One credit back per transfer
  assign ack_pop     = isc_ack_vld & isc_ack_rdy;

endmodule

// ==== isc_executor.sv ====
`timescale 1ns/1ps
`include "hpu_settings.svh"

module isc_executor (
  input  logic              prc_clk,
  input  logic              srst_n,
  input  hpu_pkg::pe_inst_t in_inst,
  input  logic              in_avail,
  input  logic              irq_clr,
  output hpu_pkg::pe_inst_t ack,
  output logic              ack_avail,
  output logic              irq_illegal
);

  import hpu_pkg::*;

  // Stages after the decode stage
  localparam int TAIL = `HPU_EXEC_LAT - 1;

  // ========================================
  // Stage 1, opcode decode
  // ========================================
  pe_op_e      s1_op;
  pe_payload_t s1_payload;
  logic        s1_avail;
  logic        s1_illegal;
  pe_inst_t    s1_ack;

  always_ff @(posedge prc_clk) begin
    if (!srst_n) begin
      s1_avail <= 1'b0;
    end else begin
      s1_avail <= in_avail;
    end
  end

  always_ff @(posedge prc_clk) begin
    s1_op      <= pe_op_e'(in_inst[`HPU_INST_W-1 -: `HPU_OP_W]);
    s1_payload <= in_inst[`HPU_INST_W-`HPU_OP_W-1:0];
  end

  always_comb begin
    case (s1_op)
      PE_OP_NOP, PE_OP_ALU, PE_OP_PBS, PE_OP_SYNC: s1_illegal = 1'b0;
      default:                                     s1_illegal = 1'b1;
    endcase
  end

  // Illegal words keep their payload under the error opcode
  assign s1_ack = s1_illegal ? {PE_OP_ERR, s1_payload} : {s1_op, s1_payload};

  // ========================================
  // Remaining stages
  // ========================================
  pe_inst_t      tail_ack [TAIL];
  logic [TAIL-1:0] tail_ill;
  logic [TAIL-1:0] tail_avail;
  // Illegal ack leaving on this cycle
  logic            ill_out;
  logic            irq_q;

  always_ff @(posedge prc_clk) begin
    if (!srst_n) begin
      tail_avail <= '0;
    end else begin
      tail_avail[0] <= s1_avail;
      for (int i = 1; i < TAIL; i++) begin
        tail_avail[i] <= tail_avail[i-1];
      end
    end
  end

  always_ff @(posedge prc_clk) begin
    tail_ack[0] <= s1_ack;
    tail_ill[0] <= s1_illegal;
    for (int i = 1; i < TAIL; i++) begin
      tail_ack[i] <= tail_ack[i-1];
      tail_ill[i] <= tail_ill[i-1];
    end
  end

  assign ill_out = tail_avail[TAIL-1] & tail_ill[TAIL-1];

  // Sticky flag, held once the illegal ack has left
  always_ff @(posedge prc_clk) begin
    if (!srst_n) begin
      irq_q <= 1'b0;
    end else if (ill_out) begin
      irq_q <= 1'b1;
    end else if (irq_clr) begin
      irq_q <= 1'b0;
    end
  end

  // High from the cycle the illegal ack leaves
  assign irq_illegal = irq_q | ill_out;

  assign ack       = tail_ack[TAIL-1];
  assign ack_avail = tail_avail[TAIL-1];

endmodule

// ==== part_pipe.sv ====
`timescale 1ns/1ps

module part_pipe #(
  parameter int DEPTH = 2
) (
  input  logic              prc_clk,
  input  logic              in_srst_n,
  input  logic              out_srst_n,
  input  hpu_pkg::pe_inst_t in_data,
  input  logic              in_avail,
  output hpu_pkg::pe_inst_t out_data,
  output logic              out_avail
);

  import hpu_pkg::*;

  if (DEPTH == 0) begin : gen_wire
    assign out_data  = in_data;
    assign out_avail = in_avail;
  end else begin : gen_pipe
    logic [DEPTH-1:0] avail_q;
    pe_inst_t         data_q [DEPTH];
    logic             first_srst_n;

    // A single stage straddles both parts, so either reset clears it
    assign first_srst_n = (DEPTH == 1) ? (in_srst_n & out_srst_n) : in_srst_n;

    // Launch stage, sender side
    always_ff @(posedge prc_clk) begin
      if (!first_srst_n) begin
        avail_q[0] <= 1'b0;
      end else begin
        avail_q[0] <= in_avail;
      end
    end

    // Remaining stages, receiver side
    for (genvar s = 1; s < DEPTH; s++) begin : gen_stage
      always_ff @(posedge prc_clk) begin
        if (!out_srst_n) begin
          avail_q[s] <= 1'b0;
        end else begin
          avail_q[s] <= avail_q[s-1];
        end
      end
    end

    // Data flops, never cleared
    always_ff @(posedge prc_clk) begin
      data_q[0] <= in_data;
      for (int i = 1; i < DEPTH; i++) begin
        data_q[i] <= data_q[i-1];
      end
    end

    assign out_data  = data_q[DEPTH-1];
    assign out_avail = avail_q[DEPTH-1];
  end

endmodule

// ==== isc_dispatch.sv ====
`timescale 1ns/1ps
`include "hpu_settings.svh"

module isc_dispatch (
  input  logic              prc_clk,
  input  logic              srst_n,
  input  hpu_pkg::pe_inst_t buf_inst,
  input  logic              buf_vld,
  output logic              buf_rdy,
  input  logic              ack_pop,
  output hpu_pkg::pe_inst_t fwd_inst,
  output logic              fwd_avail
);

  localparam int CRED_W = $clog2(`HPU_ACK_DEPTH + 1);

  // One credit per free acknowledge FIFO entry
  logic [CRED_W-1:0] credit_q;
  logic              take;

  assign buf_rdy = (credit_q != '0);
  assign take    = buf_vld & buf_rdy;

  // ========================================
  // Credit count
  // ========================================
  always_ff @(posedge prc_clk) begin
    if (!srst_n) begin
      credit_q <= CRED_W'(`HPU_ACK_DEPTH);
    end else begin
      case ({take, ack_pop})
        2'b10:   credit_q <= credit_q - 1'b1;
        2'b01:   credit_q <= credit_q + 1'b1;
        default: credit_q <= credit_q;
      endcase
    end
  end

  // ========================================
  // Issue into the forward pipe
  // ========================================
  always_ff @(posedge prc_clk) begin
    if (!srst_n) begin
      fwd_avail <= 1'b0;
    end else begin
      fwd_avail <= take;
    end
  end

  always_ff @(posedge prc_clk) begin
    if (take) begin
      fwd_inst <= buf_inst;
    end
  end

endmodule

// ==== isc_in_buffer.sv ====
`timescale 1ns/1ps

module isc_in_buffer (
  input  logic             prc_clk,
  input  logic             srst_n,
  input  hpu_pkg::pe_inst_t isc_dop,
  input  logic             isc_dop_vld,
  output logic             isc_dop_rdy,
  output hpu_pkg::pe_inst_t buf_inst,
  output logic             buf_vld,
  input  logic             buf_rdy
);

  import hpu_pkg::*;

  pe_inst_t data_q;
  logic     vld_q;
  // Holds ready low until the cycle after reset release
  logic     en_q;

  // Entry free, or draining this cycle
  assign isc_dop_rdy = en_q & (~vld_q | buf_rdy);

  always_ff @(posedge prc_clk) begin
    if (!srst_n) begin
      vld_q <= 1'b0;
      en_q  <= 1'b0;
    end else begin
      en_q <= 1'b1;
      if (isc_dop_rdy) begin
        vld_q <= isc_dop_vld;
      end
    end
  end

  always_ff @(posedge prc_clk) begin
    if (isc_dop_vld && isc_dop_rdy) begin
      data_q <= isc_dop;
    end
  end

  assign buf_inst = data_q;
  assign buf_vld  = vld_q;

endmodule

// ==== prc_reset_chain.sv ====
`timescale 1ns/1ps
`include "hpu_settings.svh"

module prc_reset_chain (
  input  logic       prc_clk,
  input  logic       cfg_srst_n,
  output logic [2:0] part_srst_n,
  output logic       prc_ce
);

  localparam int STAGES = `HPU_RST_STAGES;
  localparam int CHAIN  = 3 * STAGES;

  // Daisy chain, part 3 first, then part 2, then part 1
  logic [CHAIN-1:0] chain_q;
  logic             ce_q;

  always_ff @(posedge prc_clk) begin
    if (!cfg_srst_n) begin
      chain_q <= '0;
      ce_q    <= 1'b0;
    end else begin
      chain_q <= {chain_q[CHAIN-2:0], 1'b1};
      // Same input as the part 1 tap, so it rises with the last release
      ce_q    <= chain_q[CHAIN-2];
    end
  end

  assign prc_ce = ce_q;

  // Early taps get local padding so every part releases on one edge
  for (genvar p = 0; p < 3; p++) begin : gen_part
    localparam int TAP = (3 - p) * STAGES - 1;
    localparam int PAD = p * STAGES;

    if (PAD == 0) begin : gen_direct
      assign part_srst_n[p] = chain_q[TAP];
    end else begin : gen_pad
      logic [PAD-1:0] pad_q;

      always_ff @(posedge prc_clk) begin
        if (!cfg_srst_n) begin
          pad_q <= '0;
        end else begin
          pad_q[0] <= chain_q[TAP];
          for (int i = 1; i < PAD; i++) begin
            pad_q[i] <= pad_q[i-1];
          end
        end
      end

      assign part_srst_n[p] = pad_q[PAD-1];
    end
  end

endmodule

// ==== hpu_pkg.sv ====
`include "hpu_settings.svh"

package hpu_pkg;

  // Opcode field, values 4 to 15 are illegal on input
  typedef enum logic [`HPU_OP_W-1:0] {
    PE_OP_NOP  = 4'd0,
    PE_OP_ALU  = 4'd1,
    PE_OP_PBS  = 4'd2,
    PE_OP_SYNC = 4'd3,
    // Only ever seen in acknowledges
    PE_OP_ERR  = 4'd15
  } pe_op_e;

  // Full instruction or acknowledge word
  typedef logic [`HPU_INST_W-1:0] pe_inst_t;

  // Everything below the opcode
  typedef logic [`HPU_INST_W-`HPU_OP_W-1:0] pe_payload_t;

endpackage

// ==== hpu_settings.svh ====
`ifndef HPU_SETTINGS_SVH
`define HPU_SETTINGS_SVH

// ========================================
// Word format
// ========================================
// Instruction and acknowledge share one width
`define HPU_INST_W 32
// Opcode sits in the top bits of the word
`define HPU_OP_W 4

// ========================================
// Depths and latencies
// ========================================
// Ack FIFO entries, also the initial credit count
`define HPU_ACK_DEPTH 4
// Forward inter-part pipe, 0 to 2 stages
`define HPU_PART_PIPE 2
`define HPU_RET_PIPE 1
`define HPU_EXEC_LAT 2
// Reset chain stages per part
`define HPU_RST_STAGES 1

`endif
